/* design/bowlingPkg.sv */
////////////////////////////////////////////////////////////
// shared widths and codes for the bowling scorer
// imported by wildcard into every module header, RTL and tb
// the rules of ten-pin bowling fix every value here
////////////////////////////////////////////////////////////

package bowlingPkg;

	////////////////////////////////////////////////////////////
	// game geometry
	////////////////////////////////////////////////////////////

	localparam int NUM_FRAMES = 10;      // frames per game
	localparam int PIN_COUNT  = 10;      // pins in a full rack
	localparam int MAX_ROLLS  = 21;      // 9 frames x 2 + 3 in the tenth

	////////////////////////////////////////////////////////////
	// widths
	////////////////////////////////////////////////////////////

	localparam int PIN_W         = 4;    // 0..10 pins
	localparam int ROLL_IDX_W    = 5;    // roll index 0..20, count 0..21
	localparam int FRAME_IDX_W   = 4;    // frame 0..9
	localparam int FRAME_SCORE_W = 6;    // one frame tops out at 30
	localparam int TOTAL_W       = 9;    // perfect game is 300

	////////////////////////////////////////////////////////////
	// frame kinds
	////////////////////////////////////////////////////////////

	localparam int KIND_W = 2;

	// open is the zero code, so a frame not yet closed reads open
	localparam logic [KIND_W-1:0] KIND_OPEN   = 2'd0;
	localparam logic [KIND_W-1:0] KIND_SPARE  = 2'd1;  // ten on two balls
	localparam logic [KIND_W-1:0] KIND_STRIKE = 2'd2;  // ten on first ball

	// note: code 2'd3 never produced

endpackage

/* design/frameTracker.sv */
////////////////////////////////////////////////////////////
// frame tracker for the bowling scorer
// follows frame and ball position on every accepted roll,
// tags each frame open/spare/strike, notes its first roll index
// and closes the game after the tenth frame
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module frameTracker import bowlingPkg::*; (
	input  logic                              button,          // roll clock
	input  logic                              arstN,
	input  logic [PIN_W-1:0]                  pinsIn,
	input  logic [ROLL_IDX_W-1:0]             rollCount,       // index the ledger writes next
	output logic                              gameOver,
	output logic [NUM_FRAMES*KIND_W-1:0]      frameKinds,      // kind code per frame
	output logic [NUM_FRAMES*ROLL_IDX_W-1:0]  frameFirstRoll,  // first roll index per frame
	output logic                              tenthDone
);

	localparam int LAST_FRAME = NUM_FRAMES - 1;

	////////////////////////////////////////////////////////////
	// position state
	////////////////////////////////////////////////////////////

	logic [FRAME_IDX_W-1:0] curFrame;   // 0..9
	logic [1:0]             ball;       // ball within frame, 2 only in tenth
	logic [PIN_W-1:0]       firstPins;  // pins on first ball of current frame
	logic [PIN_W:0]         pairSum;    // first + second ball, one bit wider
	logic                   isTenth;
	logic                   isStrike;   // current ball knocks the full rack

	assign pairSum  = {1'b0, firstPins} + {1'b0, pinsIn};
	assign isTenth  = (curFrame == FRAME_IDX_W'(LAST_FRAME));
	assign isStrike = (pinsIn == PIN_W'(PIN_COUNT));

	// game ends exactly when the tenth frame closes
	assign gameOver = tenthDone;

	////////////////////////////////////////////////////////////
	// frame walk
	////////////////////////////////////////////////////////////

	always_ff @(posedge button or negedge arstN) begin
		if (!arstN) begin
			curFrame       <= '0;
			ball           <= 2'd0;
			firstPins      <= '0;
			frameKinds     <= '0;            // everything open
			frameFirstRoll <= '1;            // all ones = frame not started
			tenthDone      <= 1'b0;
		end else if (!tenthDone) begin
			case (ball)
				2'd0: begin
					// first ball, remember where the frame starts in the ledger
					frameFirstRoll[curFrame*ROLL_IDX_W +: ROLL_IDX_W] <= rollCount;
					firstPins <= pinsIn;
					if (isStrike) begin
						frameKinds[curFrame*KIND_W +: KIND_W] <= KIND_STRIKE;
						if (isTenth)
							ball <= 2'd1;          // tenth keeps rolling
						else
							curFrame <= curFrame + 1'b1;  // strike closes the frame
					end else begin
						ball <= 2'd1;
					end
				end
				2'd1: begin
					if (isTenth) begin
						// bonus ball only after strike or spare
						if (firstPins == PIN_W'(PIN_COUNT)) begin
							ball <= 2'd2;          // kind already strike
						end else if (pairSum == (PIN_W+1)'(PIN_COUNT)) begin
							frameKinds[curFrame*KIND_W +: KIND_W] <= KIND_SPARE;
							ball <= 2'd2;
						end else begin
							tenthDone <= 1'b1;     // open tenth, game over
						end
					end else begin
						if (pairSum == (PIN_W+1)'(PIN_COUNT))
							frameKinds[curFrame*KIND_W +: KIND_W] <= KIND_SPARE;
						else
							frameKinds[curFrame*KIND_W +: KIND_W] <= KIND_OPEN;
						curFrame <= curFrame + 1'b1;
						ball     <= 2'd0;
					end
				end
				default: begin
					tenthDone <= 1'b1;             // third ball of the tenth
				end
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////

	// second ball in frames 1..9 cannot beat the pins left standing
	secondBallLegal: assert property (@(posedge button) disable iff (!arstN)
		(!tenthDone && ball == 2'd1 && !isTenth) |->
			(pairSum <= (PIN_W+1)'(PIN_COUNT)))
		else $error("second ball %0d after %0d pins exceeds rack", pinsIn, firstPins);

endmodule

/* design/rollLedger.sv */
////////////////////////////////////////////////////////////
// roll ledger for the bowling scorer
// keeps the pin count of every accepted roll, in order,
// plus the number of rolls taken so far
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rollLedger import bowlingPkg::*; (
	input  logic                         button,
	input  logic                         arstN,
	input  logic [PIN_W-1:0]             pinsIn,
	input  logic                         gameOver,   // freezes the ledger
	output logic [ROLL_IDX_W-1:0]        rollCount,  // rolls recorded
	output logic [MAX_ROLLS*PIN_W-1:0]   rollPins    // roll i at [i*PIN_W +: PIN_W]
);

	logic acceptRoll;

	// a roll counts only while the game runs
	assign acceptRoll = !gameOver && (rollCount < ROLL_IDX_W'(MAX_ROLLS));

	////////////////////////////////////////////////////////////
	// roll counter
	////////////////////////////////////////////////////////////

	always_ff @(posedge button or negedge arstN) begin
		if (!arstN)
			rollCount <= '0;
		else if (acceptRoll)
			rollCount <= rollCount + 1'b1;  // next free slot
	end

	////////////////////////////////////////////////////////////
	// pin history
	////////////////////////////////////////////////////////////

	// stale entries past rollCount are never scored
	always_ff @(posedge button) begin
		if (arstN && acceptRoll)
			rollPins[rollCount*PIN_W +: PIN_W] <= pinsIn;
	end

	////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////

	// tracker must close the game before the ledger runs out
	rollCountBound: assert property (@(posedge button) disable iff (!arstN)
		!gameOver |-> (rollCount < ROLL_IDX_W'(MAX_ROLLS)))
		else $error("game still open with all %0d roll slots used", rollCount);

	// no roll can knock more than a full rack
	rollPinsLegal: assert property (@(posedge button) disable iff (!arstN)
		!gameOver |-> (pinsIn <= PIN_W'(PIN_COUNT)))
		else $error("illegal roll of %0d pins", pinsIn);

endmodule

/* design/frameScorer.sv */
////////////////////////////////////////////////////////////
// frame scorer for the bowling scorer
// combinational from tracker and ledger state: per-frame score
// and ready flag, the frameSel readout and the running total
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module frameScorer import bowlingPkg::*; (
	input  logic [NUM_FRAMES*KIND_W-1:0]      frameKinds,
	input  logic [NUM_FRAMES*ROLL_IDX_W-1:0]  frameFirstRoll,
	input  logic [ROLL_IDX_W-1:0]             rollCount,
	input  logic [MAX_ROLLS*PIN_W-1:0]        rollPins,
	input  logic                              tenthDone,
	input  logic [FRAME_IDX_W-1:0]            frameSel,
	output logic [FRAME_SCORE_W-1:0]          frameScore,  // selected frame, 0 if not ready
	output logic                              frameReady,
	output logic [TOTAL_W-1:0]                gameTotal    // sum of ready frames
);

	localparam int LAST_FRAME = NUM_FRAMES - 1;

	logic [FRAME_SCORE_W-1:0] rawScore [NUM_FRAMES];  // valid only once ready
	logic [NUM_FRAMES-1:0]    readyVec;

	// ledger lookup, zero past the end (unstarted frames point there)
	function automatic logic [PIN_W-1:0] pinAt(input logic [ROLL_IDX_W:0] idx);
		pinAt = '0;
		if (idx < (ROLL_IDX_W+1)'(MAX_ROLLS))
			pinAt = rollPins[idx*PIN_W +: PIN_W];
	endfunction

	////////////////////////////////////////////////////////////
	// per-frame score and ready
	////////////////////////////////////////////////////////////

	for (genvar f = 0; f < NUM_FRAMES; f++) begin : gFrame
		logic [KIND_W-1:0]     kind;
		logic [ROLL_IDX_W:0]   first;   // one bit wider, all ones = not started
		logic [FRAME_SCORE_W-1:0] bonus;

		assign kind  = frameKinds[f*KIND_W +: KIND_W];
		assign first = {1'b0, frameFirstRoll[f*ROLL_IDX_W +: ROLL_IDX_W]};

		// strike: 10 + next two, spare: 10 + next one, tenth: its own balls
		// all three reduce to the first three ledger entries of the frame
		assign bonus = (kind == KIND_OPEN) ? '0 : FRAME_SCORE_W'(pinAt(first + 2'd2));
		assign rawScore[f] = FRAME_SCORE_W'(pinAt(first))
			+ FRAME_SCORE_W'(pinAt(first + 1'b1)) + bonus;

		if (f == LAST_FRAME) begin : gTenth
			assign readyVec[f] = tenthDone;  // tenth settles with the game
		end else begin : gEarly
			logic [ROLL_IDX_W:0] need;     // rolls from first until ready

			assign need = (kind == KIND_OPEN) ? (ROLL_IDX_W+1)'(2) : (ROLL_IDX_W+1)'(3);
			assign readyVec[f] = ((first + need) <= {1'b0, rollCount});
		end

		// a settled frame never scores past three full racks
		always_comb begin
			if (readyVec[f])
				assert (rawScore[f] <= FRAME_SCORE_W'(3*PIN_COUNT))
				else $error("frame %0d scores %0d", f, rawScore[f]);
		end
	end

	////////////////////////////////////////////////////////////
	// readout
	////////////////////////////////////////////////////////////

	always_comb begin
		frameReady = 1'b0;
		frameScore = '0;
		if (frameSel < FRAME_IDX_W'(NUM_FRAMES)) begin  // 10..15 read as empty
			frameReady = readyVec[frameSel];
			if (frameReady)
				frameScore = rawScore[frameSel];
		end
	end

	////////////////////////////////////////////////////////////
	// running total
	////////////////////////////////////////////////////////////

	always_comb begin
		gameTotal = '0;
		for (int f = 0; f < NUM_FRAMES; f++) begin
			if (readyVec[f])
				gameTotal = gameTotal + TOTAL_W'(rawScore[f]);  // pending bonus frames skipped
		end
	end

endmodule

/* design/bowlingScorer.sv */
////////////////////////////////////////////////////////////
// ten-pin bowling scorer, top level
// each rising button edge takes pinsIn as one roll; frame
// scores read out through frameSel, total and game over live
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module bowlingScorer import bowlingPkg::*; (
	input  logic                      button,      // one edge per roll
	input  logic                      arstN,
	input  logic [PIN_W-1:0]          pinsIn,
	input  logic [FRAME_IDX_W-1:0]    frameSel,
	output logic [FRAME_SCORE_W-1:0]  frameScore,
	output logic                      frameReady,
	output logic [TOTAL_W-1:0]        gameTotal,
	output logic                      gameOver
);

	// tracker to scorer
	logic [NUM_FRAMES*KIND_W-1:0]      frameKinds;
	logic [NUM_FRAMES*ROLL_IDX_W-1:0]  frameFirstRoll;
	logic                              tenthDone;

	// ledger to tracker and scorer
	logic [ROLL_IDX_W-1:0]             rollCount;
	logic [MAX_ROLLS*PIN_W-1:0]        rollPins;

	////////////////////////////////////////////////////////////
	// tracker and ledger both step on every accepted roll
	////////////////////////////////////////////////////////////

	frameTracker uTracker (
		.button         (button),
		.arstN          (arstN),
		.pinsIn         (pinsIn),
		.rollCount      (rollCount),
		.gameOver       (gameOver),
		.frameKinds     (frameKinds),
		.frameFirstRoll (frameFirstRoll),
		.tenthDone      (tenthDone)
	);

	rollLedger uLedger (
		.button    (button),
		.arstN     (arstN),
		.pinsIn    (pinsIn),
		.gameOver  (gameOver),
		.rollCount (rollCount),
		.rollPins  (rollPins)
	);

	frameScorer uScorer (
		.frameKinds     (frameKinds),
		.frameFirstRoll (frameFirstRoll),
		.rollCount      (rollCount),
		.rollPins       (rollPins),
		.tenthDone      (tenthDone),
		.frameSel       (frameSel),
		.frameScore     (frameScore),
		.frameReady     (frameReady),
		.gameTotal      (gameTotal)
	);

endmodule

/* testbench/scoreChecker.sv */
////////////////////////////////////////////////////////////
// score checker for the bowling scorer testbench
// watches the DUT ports, keeps its own roll list and scores
// it by the game rules; counts checks and errors
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module scoreChecker import bowlingPkg::*; (
	input logic                      button,
	input logic                      arstN,
	input logic [PIN_W-1:0]          pinsIn,
	input logic [FRAME_IDX_W-1:0]    frameSel,
	input logic [FRAME_SCORE_W-1:0]  frameScore,
	input logic                      frameReady,
	input logic [TOTAL_W-1:0]        gameTotal,
	input logic                      gameOver
);

	int    errorCount = 0;
	int    checkCount = 0;
	string gameName = "none";     // set by the testbench per game
	bit    armed = 1'b0;          // first reset seen

	int rolls [MAX_ROLLS];        // own copy of the rolls
	int numRolls = 0;

	// expected state rebuilt from the roll list on demand
	int expScore [NUM_FRAMES];
	bit expReady [NUM_FRAMES];
	bit expOver;
	int expTotal;

	////////////////////////////////////////////////////////////
	// reference scoring by the rules
	////////////////////////////////////////////////////////////

	function automatic void applyRules();
		int idx;
		int need;
		idx = 0;
		expOver = 1'b0;
		expTotal = 0;
		for (int f = 0; f < NUM_FRAMES; f++) begin
			expScore[f] = 0;
			expReady[f] = 1'b0;
		end
		for (int f = 0; f < NUM_FRAMES; f++) begin
			if (numRolls - idx < 1)
				break;                            // frame not started
			if (f == NUM_FRAMES - 1) begin
				if (numRolls - idx >= 2) begin
					// third ball only after strike or spare
					need = (rolls[idx] + rolls[idx+1] >= PIN_COUNT) ? 3 : 2;
					if (numRolls - idx >= need) begin
						expReady[f] = 1'b1;
						expOver = 1'b1;
						for (int b = 0; b < need; b++)
							expScore[f] += rolls[idx+b];
					end
				end
			end else if (rolls[idx] == PIN_COUNT) begin
				if (numRolls - idx >= 3) begin    // strike waits for two more
					expReady[f] = 1'b1;
					expScore[f] = PIN_COUNT + rolls[idx+1] + rolls[idx+2];
				end
				idx += 1;
			end else begin
				if (numRolls - idx < 2)
					break;                        // second ball still to come
				if (rolls[idx] + rolls[idx+1] == PIN_COUNT) begin
					if (numRolls - idx >= 3) begin
						expReady[f] = 1'b1;
						expScore[f] = PIN_COUNT + rolls[idx+2];
					end
				end else begin
					expReady[f] = 1'b1;           // open frame
					expScore[f] = rolls[idx] + rolls[idx+1];
				end
				idx += 2;
			end
		end
		for (int f = 0; f < NUM_FRAMES; f++)
			if (expReady[f])
				expTotal += expScore[f];
	endfunction

	function automatic void checkValue(string label, int expected, int actual);
		checkCount++;
		if (expected != actual) begin
			errorCount++;
			$display("FAIL %0s %0s: expected %0d, actual %0d",
				gameName, label, expected, actual);
		end
	endfunction

	function automatic void checkReadout();
		int sel;
		sel = int'(frameSel);
		if (sel < NUM_FRAMES) begin
			checkValue($sformatf("frameReady[%0d]", sel), int'(expReady[sel]), int'(frameReady));
			checkValue($sformatf("frameScore[%0d]", sel),
				expReady[sel] ? expScore[sel] : 0, int'(frameScore));
		end else begin
			checkValue("frameReady out of range", 0, int'(frameReady));
			checkValue("frameScore out of range", 0, int'(frameScore));
		end
	endfunction

	// final totals against the table value or the model when none is given
	function automatic void endGame(int tableTotal);
		applyRules();
		checkValue("gameOver at end", 1, int'(gameOver));
		checkValue("final gameTotal", (tableTotal < 0) ? expTotal : tableTotal, int'(gameTotal));
	endfunction

	////////////////////////////////////////////////////////////
	// roll capture and sampling
	////////////////////////////////////////////////////////////

	always @(posedge button or negedge arstN) begin
		if (!arstN) begin
			armed = 1'b1;
			numRolls = 0;                     // model restarts with the DUT
		end else if (armed) begin
			applyRules();
			if (!expOver && numRolls < MAX_ROLLS) begin
				rolls[numRolls] = int'(pinsIn);
				numRolls++;
			end
		end
	end

	// mid-cycle total and game over have settled since the edge
	always @(negedge button) begin
		if (armed) begin
			applyRules();
			checkValue("gameTotal", expTotal, int'(gameTotal));
			checkValue("gameOver", int'(expOver), int'(gameOver));
		end
	end

	// readout sweep sampled half a step after each select change
	always @(frameSel) begin
		#0.5;
		if (armed) begin
			applyRules();
			checkReadout();
		end
	end

endmodule

/* include/gameTable.svh */
////////////////////////////////////////////////////////////
// named test games for the bowling scorer testbench
// include inside a module that imports bowlingPkg; row g holds
// GAME_LEN[g] rolls, zero padded, and the hand-scored total
////////////////////////////////////////////////////////////

`ifndef GAME_TABLE_SVH
`define GAME_TABLE_SVH

localparam int NUM_GAMES  = 5;
localparam int NAME_CHARS = 12;  // names print with %s

localparam bit [8*NAME_CHARS-1:0] GAME_NAME [NUM_GAMES] = '{
	"gutterGame", "nineZero", "allSpares", "perfectGame", "mixedGame"
};

localparam int GAME_LEN   [NUM_GAMES] = '{20, 20, 21, 12, 17};
localparam int GAME_TOTAL [NUM_GAMES] = '{0, 90, 150, 300, 167};

localparam logic [PIN_W-1:0] GAME_ROLLS [NUM_GAMES][MAX_ROLLS] = '{
	'{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0},
	'{9, 0, 9, 0, 9, 0, 9, 0, 9, 0, 9, 0, 9, 0, 9, 0, 9, 0, 9, 0, 0},
	'{5, 5, 5, 5, 5, 5, 5, 5, 5, 5, 5, 5, 5, 5, 5, 5, 5, 5, 5, 5, 5},
	'{10, 10, 10, 10, 10, 10, 10, 10, 10, 10, 10, 10, 0, 0, 0, 0, 0, 0, 0, 0, 0},
	// X, 7/, 9-, X, -8, 8/, -6, X, X, X81
	'{10, 7, 3, 9, 0, 10, 0, 8, 8, 2, 0, 6, 10, 10, 10, 8, 1, 0, 0, 0, 0}
};

`endif

/* testbench/bowlingTb.sv */
////////////////////////////////////////////////////////////
// testbench for the bowling scorer
// plays the table games, then one random game with a reset
// part way through; scoreChecker does all the comparing
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module bowlingTb import bowlingPkg::*; ();

	`include "gameTable.svh"

	localparam int CLK_PERIOD  = 20;
	localparam int WATCHDOG_NS = (NUM_GAMES + 1) * 30 * CLK_PERIOD;  // 30 cycles per game
	localparam int PRE_RESET   = 6;  // random rolls before the mid-game reset

	logic                      button;
	logic                      arstN;
	logic [PIN_W-1:0]          pinsIn;
	logic [FRAME_IDX_W-1:0]    frameSel;
	logic [FRAME_SCORE_W-1:0]  frameScore;
	logic                      frameReady;
	logic [TOTAL_W-1:0]        gameTotal;
	logic                      gameOver;

	bit [31:0] lcgState = 32'ha8b6;
	int        gameRolls [$];        // rolls of the game being played

	bowlingScorer u_dut (
		.button     (button),
		.arstN      (arstN),
		.pinsIn     (pinsIn),
		.frameSel   (frameSel),
		.frameScore (frameScore),
		.frameReady (frameReady),
		.gameTotal  (gameTotal),
		.gameOver   (gameOver)
	);

	scoreChecker uChecker (
		.button     (button),
		.arstN      (arstN),
		.pinsIn     (pinsIn),
		.frameSel   (frameSel),
		.frameScore (frameScore),
		.frameReady (frameReady),
		.gameTotal  (gameTotal),
		.gameOver   (gameOver)
	);

	initial begin
		button = 1'b0;
		forever #(CLK_PERIOD / 2) button = ~button;
	end

	////////////////////////////////////////////////////////////
	// helpers entered 2 ns after a rising edge
	////////////////////////////////////////////////////////////

	function automatic int nextRand(int range);
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return int'((lcgState >> 8) % 32'(range));  // low bits are weak
	endfunction

	function automatic string nameOf(int g);
		string s;
		s = "";
		for (int i = NAME_CHARS - 1; i >= 0; i--)
			if (GAME_NAME[g][8*i +: 8] != 8'd0)
				s = $sformatf("%s%c", s, GAME_NAME[g][8*i +: 8]);
		return s;
	endfunction

	// readout swept while held in reset so every frame reads cleared
	task automatic resetDut();
		pinsIn = '0;
		arstN = 1'b0;
		for (int s = 0; s < NUM_FRAMES; s++) begin
			frameSel = FRAME_IDX_W'(s);
			#1;
		end
		repeat (4) @(posedge button);
		#2 arstN = 1'b1;
	endtask

	// one roll with frameSel swept over every code while it waits
	task automatic rollOnce(int pins);
		pinsIn = PIN_W'(pins);
		for (int s = 0; s < (1 << FRAME_IDX_W); s++) begin
			frameSel = FRAME_IDX_W'(s);
			#1;
		end
		@(posedge button);
		#2;
	endtask

	task automatic playGame(string name, int tableTotal);
		uChecker.gameName = name;
		resetDut();
		foreach (gameRolls[i])
			rollOnce(gameRolls[i]);
		uChecker.endGame(tableTotal);
		repeat (2)
			rollOnce(nextRand(PIN_COUNT + 1));  // edges after game over
		uChecker.endGame(tableTotal);        // nothing may have moved
	endtask

	// legal random game built one frame at a time
	task automatic buildRandomGame();
		int a;
		int b;
		gameRolls.delete();
		for (int f = 0; f < NUM_FRAMES - 1; f++) begin
			a = nextRand(PIN_COUNT + 1);
			gameRolls.push_back(a);
			if (a != PIN_COUNT)
				gameRolls.push_back(nextRand(PIN_COUNT + 1 - a));
		end
		a = nextRand(PIN_COUNT + 1);
		b = nextRand((a == PIN_COUNT) ? PIN_COUNT + 1 : PIN_COUNT + 1 - a);
		gameRolls.push_back(a);
		gameRolls.push_back(b);
		if (a == PIN_COUNT)
			gameRolls.push_back(nextRand((b == PIN_COUNT) ? PIN_COUNT + 1 : PIN_COUNT + 1 - b));
		else if (a + b == PIN_COUNT)
			gameRolls.push_back(nextRand(PIN_COUNT + 1));  // spare bonus ball
	endtask

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////

	initial begin
		arstN = 1'b1;
		pinsIn = '0;
		frameSel = '0;
		@(posedge button);
		#2;
		for (int g = 0; g < NUM_GAMES; g++) begin
			gameRolls.delete();
			for (int i = 0; i < GAME_LEN[g]; i++)
				gameRolls.push_back(int'(GAME_ROLLS[g][i]));
			playGame(nameOf(g), GAME_TOTAL[g]);
		end
		buildRandomGame();
		uChecker.gameName = "randomGame";
		resetDut();                          // fresh game so the first rolls count
		for (int i = 0; i < PRE_RESET; i++)
			rollOnce(gameRolls[i]);
		playGame("randomGame", -1);         // opens with the mid-game reset
		$display("closing: %0d checks, %0d errors", uChecker.checkCount, uChecker.errorCount);
		if (uChecker.errorCount == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

	// watchdog
	initial begin
		#(WATCHDOG_NS);
		$display("timeout: games still running after %0d ns", WATCHDOG_NS);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

/* tb.f */
+incdir+include
design/bowlingPkg.sv
design/frameTracker.sv
design/rollLedger.sv
design/frameScorer.sv
design/bowlingScorer.sv
testbench/scoreChecker.sv
testbench/bowlingTb.sv

/* run.sh */
#!/bin/sh
# build and run the bowling scorer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f tb.f --top-module bowlingTb -o bowlingSim

./obj_dir/bowlingSim > sim.log 2>&1
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
	echo "simulation reported failures"
	exit 1
fi
echo "simulation clean"
